// ==== hw/rv32i_decode_pkg.sv ====
// Shared types and encodings for the RV32I decode stage.
// ALU op, zone and immediate type encodings are internal to this design.

`default_nettype none

package rv32i_decode_pkg;

    typedef logic [31:0] ins_word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [6:0]  opcode_t;

    // ------------------------------------------------------------------------
    // major opcodes
    // ------------------------------------------------------------------------
    localparam opcode_t OPC_LUI     = 7'b0110111;
    localparam opcode_t OPC_AUIPC   = 7'b0010111;
    localparam opcode_t OPC_JAL     = 7'b1101111;
    localparam opcode_t OPC_JALR    = 7'b1100111;
    localparam opcode_t OPC_BRANCH  = 7'b1100011;
    localparam opcode_t OPC_LOAD    = 7'b0000011;
    localparam opcode_t OPC_STORE   = 7'b0100011;
    localparam opcode_t OPC_OPIMM   = 7'b0010011;
    localparam opcode_t OPC_OP      = 7'b0110011;
    localparam opcode_t OPC_MISCMEM = 7'b0001111;
    localparam opcode_t OPC_SYSTEM  = 7'b1110011;

    // minor opcodes
    localparam funct3_t F3_ADDSUB = 3'b000;
    localparam funct3_t F3_SLL    = 3'b001;
    localparam funct3_t F3_SLT    = 3'b010;
    localparam funct3_t F3_SLTU   = 3'b011;
    localparam funct3_t F3_XOR    = 3'b100;
    localparam funct3_t F3_SRLSRA = 3'b101;
    localparam funct3_t F3_OR     = 3'b110;
    localparam funct3_t F3_AND    = 3'b111;
    localparam funct3_t F3_PRIV   = 3'b000;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // sub, sra

    // ------------------------------------------------------------------------
    // decode result types
    // ------------------------------------------------------------------------
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_MOV
    } alu_op_e;

    typedef enum logic [1:0] {
        ZONE_NONE, ZONE_REGFILE, ZONE_LOADQ, ZONE_STOREQ
    } zone_e;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_I, IMM_I_ZIMM, IMM_S, IMM_SB, IMM_U, IMM_UJ
    } imm_type_e;

    typedef struct packed {
        logic    ins_err;
        logic    fencei;
        logic    wfi;
        logic    jump;
        logic    ecall;
        logic    conditional;
        logic    link;
        logic    regd_tgt;
        logic    regs1_rd;
        logic    regs2_rd;
        logic    sels1_pc;
        logic    sels2_imm;
        logic    selcmps2_imm;
        logic    sel_csr_wr_data_imm;
        logic    csr_rd;
        logic    csr_wr;
        zone_e   zone;
        alu_op_e aluop;
    } decode_ctrl_t;

    typedef struct packed {
        logic ins_err;
        logic ecall;
        logic wfi;
        logic csr_rd;
        logic csr_wr;
        logic regd_tgt;
        logic regs1_rd;
        logic sel_csr_wr_data_imm;
        logic imm_zimm; // csr source is the zero-extended rs1 field
    } sys_ctrl_t;

endpackage

`default_nettype wire

// ==== hw/rv32i_imm_gen.sv ====
// Immediate assembly. Sign extension from bit 31 works for XLEN >= 32.

`timescale 1ns/1ps
`default_nettype none

module rv32i_imm_gen import rv32i_decode_pkg::*; #(
    parameter int unsigned XLEN = 32
) (
    input  ins_word_t        ins_i,
    input  imm_type_e        imm_type_i,
    output logic [XLEN-1:0]  imm_o
);

    logic sign;

    assign sign = ins_i[31];

    always_comb begin
        case (imm_type_i)
            IMM_I:      imm_o = {{(XLEN-11){sign}}, ins_i[30:20]};
            IMM_I_ZIMM: imm_o = {{(XLEN-5){1'b0}}, ins_i[19:15]}; // csr uimm
            IMM_S:      imm_o = {{(XLEN-11){sign}}, ins_i[30:25], ins_i[11:7]};
            IMM_SB: begin
                imm_o = {{(XLEN-12){sign}}, ins_i[7], ins_i[30:25], ins_i[11:8], 1'b0};
            end
            IMM_U:      imm_o = {{(XLEN-31){sign}}, ins_i[30:12], 12'b0};
            IMM_UJ: begin
                imm_o = {{(XLEN-20){sign}}, ins_i[19:12], ins_i[20], ins_i[30:21], 1'b0};
            end
            default:    imm_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/rv32i_system_decoder.sv ====
// Field decode for MISC-MEM and SYSTEM. Outputs are only meaningful when
// the major decoder sees the matching opcode. FENCE is reported as FENCE.I.

`timescale 1ns/1ps
`default_nettype none

module rv32i_system_decoder import rv32i_decode_pkg::*; (
    input  ins_word_t ins_i,
    output sys_ctrl_t sys_ctrl_o,
    output logic      fence_ok_o
);

    localparam funct3_t    F3_FENCE  = 3'b000;
    localparam funct3_t    F3_FENCEI = 3'b001;
    localparam logic [11:0] IMM_ECALL = 12'h000;
    localparam logic [11:0] IMM_WFI   = 12'h105;

    funct3_t     funct3;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    logic [11:0] imm12;
    logic        rd_zero;
    logic        rs1_zero;

    assign funct3   = ins_i[14:12];
    assign rd       = ins_i[11:7];
    assign rs1      = ins_i[19:15];
    assign imm12    = ins_i[31:20];
    assign rd_zero  = (rd == '0);
    assign rs1_zero = (rs1 == '0);

    // ------------------------------------------------------------------------
    // fence legality
    // ------------------------------------------------------------------------
    assign fence_ok_o =
        (funct3 == F3_FENCE && ins_i[31:28] == 4'b0 && rs1_zero && rd_zero) ||
        (funct3 == F3_FENCEI && ins_i[31:15] == 17'b0 && rd_zero);

    // ------------------------------------------------------------------------
    // priv and csr forms
    // ------------------------------------------------------------------------
    always_comb begin
        sys_ctrl_o = '0;

        if (funct3 == F3_PRIV) begin
            if (!rd_zero || !rs1_zero) begin
                sys_ctrl_o.ins_err = 1'b1;
            end else if (imm12 == IMM_ECALL) begin
                sys_ctrl_o.ecall = 1'b1;
            end else if (imm12 == IMM_WFI) begin
                sys_ctrl_o.wfi = 1'b1;
            end else begin
                sys_ctrl_o.ins_err = 1'b1; // ebreak, xret, sfence.vma
            end
        end else if (funct3[1:0] != 2'b00) begin
            sys_ctrl_o.regd_tgt = 1'b1;
            sys_ctrl_o.csr_rd   = !rd_zero;
            sys_ctrl_o.csr_wr   = !rs1_zero || (funct3[1:0] == 2'b01); // csrrw always writes
            if (funct3[2]) begin
                sys_ctrl_o.sel_csr_wr_data_imm = 1'b1;
                sys_ctrl_o.imm_zimm            = 1'b1;
            end else begin
                sys_ctrl_o.regs1_rd = 1'b1;
            end
        end else begin
            sys_ctrl_o.ins_err = 1'b1; // funct3 100
        end
    end

endmodule

`default_nettype wire

// ==== hw/rv32i_major_decoder.sv ====
// Combinational major opcode dispatch. SYSTEM and MISC-MEM detail comes
// from rv32i_system_decoder; only this block looks at the opcode.

`timescale 1ns/1ps
`default_nettype none

module rv32i_major_decoder import rv32i_decode_pkg::*; (
    input  ins_word_t    ins_i,
    input  sys_ctrl_t    sys_ctrl_i,
    input  logic         fence_ok_i,
    output decode_ctrl_t ctrl_o,
    output imm_type_e    imm_type_o
);

    opcode_t    opcode;
    funct3_t    funct3;
    logic [6:0] funct7;
    logic       f7_base;
    logic       f7_alt;

    assign opcode  = ins_i[6:0];
    assign funct3  = ins_i[14:12];
    assign funct7  = ins_i[31:25];
    assign f7_base = (funct7 == F7_BASE);
    assign f7_alt  = (funct7 == F7_ALT);

    // shared by OP and OP-IMM, alt picks sub/sra
    function automatic alu_op_e alu_op_f(input funct3_t f3, input logic alt);
        case (f3)
            F3_ADDSUB: alu_op_f = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:    alu_op_f = ALU_SLL;
            F3_SLT:    alu_op_f = ALU_SLT;
            F3_SLTU:   alu_op_f = ALU_SLTU;
            F3_XOR:    alu_op_f = ALU_XOR;
            F3_SRLSRA: alu_op_f = alt ? ALU_SRA : ALU_SRL;
            F3_OR:     alu_op_f = ALU_OR;
            default:   alu_op_f = ALU_AND;
        endcase
    endfunction

    always_comb begin
        ctrl_o     = '0;
        imm_type_o = IMM_NONE;

        case (opcode)
            OPC_LUI: begin
                imm_type_o         = IMM_U;
                ctrl_o.zone        = ZONE_REGFILE;
                ctrl_o.regd_tgt    = 1'b1;
                ctrl_o.aluop       = ALU_MOV;
                ctrl_o.sels2_imm   = 1'b1;
            end
            OPC_AUIPC, OPC_JAL: begin
                imm_type_o         = (opcode == OPC_JAL) ? IMM_UJ : IMM_U;
                ctrl_o.jump        = (opcode == OPC_JAL);
                ctrl_o.link        = (opcode == OPC_JAL);
                ctrl_o.zone        = ZONE_REGFILE;
                ctrl_o.regd_tgt    = 1'b1;
                ctrl_o.sels1_pc    = 1'b1;
                ctrl_o.sels2_imm   = 1'b1;
            end
            OPC_JALR: begin
                imm_type_o         = IMM_I;
                ctrl_o.jump        = 1'b1;
                ctrl_o.link        = 1'b1;
                ctrl_o.zone        = ZONE_REGFILE;
                ctrl_o.regd_tgt    = 1'b1;
                ctrl_o.regs1_rd    = 1'b1;
                ctrl_o.sels2_imm   = 1'b1;
                ctrl_o.ins_err     = (funct3 != 3'b000);
            end
            OPC_BRANCH: begin
                imm_type_o         = IMM_SB;
                ctrl_o.jump        = 1'b1;
                ctrl_o.conditional = 1'b1;
                ctrl_o.regs1_rd    = 1'b1;
                ctrl_o.regs2_rd    = 1'b1;
                ctrl_o.sels1_pc    = 1'b1;
                ctrl_o.sels2_imm   = 1'b1;
                ctrl_o.ins_err     = (funct3 == 3'b010) || (funct3 == 3'b011);
            end
            OPC_LOAD: begin
                imm_type_o         = IMM_I;
                ctrl_o.zone        = ZONE_LOADQ;
                ctrl_o.regd_tgt    = 1'b1;
                ctrl_o.regs1_rd    = 1'b1;
                ctrl_o.sels2_imm   = 1'b1;
                ctrl_o.ins_err     = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
            end
            OPC_STORE: begin
                imm_type_o         = IMM_S;
                ctrl_o.zone        = ZONE_STOREQ;
                ctrl_o.regs1_rd    = 1'b1;
                ctrl_o.regs2_rd    = 1'b1;
                ctrl_o.sels2_imm   = 1'b1;
                ctrl_o.ins_err     = (funct3[2] == 1'b1) || (funct3 == 3'b011);
            end
            OPC_OPIMM: begin
                imm_type_o          = IMM_I;
                ctrl_o.zone         = ZONE_REGFILE;
                ctrl_o.regd_tgt     = 1'b1;
                ctrl_o.regs1_rd     = 1'b1;
                ctrl_o.sels2_imm    = 1'b1;
                ctrl_o.aluop        = alu_op_f(funct3, (funct3 == F3_SRLSRA) && f7_alt);
                ctrl_o.selcmps2_imm = (funct3 == F3_SLT) || (funct3 == F3_SLTU);
                // funct7 is immediate except for shifts
                if (funct3 == F3_SLL) begin
                    ctrl_o.ins_err = !f7_base;
                end else if (funct3 == F3_SRLSRA) begin
                    ctrl_o.ins_err = !(f7_base || f7_alt);
                end
            end
            OPC_OP: begin
                ctrl_o.zone     = ZONE_REGFILE;
                ctrl_o.regd_tgt = 1'b1;
                ctrl_o.regs1_rd = 1'b1;
                ctrl_o.regs2_rd = 1'b1;
                ctrl_o.aluop    = alu_op_f(funct3, f7_alt);
                ctrl_o.ins_err  = !(f7_base || (f7_alt &&
                                  (funct3 == F3_ADDSUB || funct3 == F3_SRLSRA)));
            end
            OPC_MISCMEM: begin
                ctrl_o.fencei  = fence_ok_i;
                ctrl_o.ins_err = !fence_ok_i;
            end
            OPC_SYSTEM: begin
                ctrl_o.ins_err             = sys_ctrl_i.ins_err;
                ctrl_o.ecall               = sys_ctrl_i.ecall;
                ctrl_o.wfi                 = sys_ctrl_i.wfi;
                ctrl_o.csr_rd              = sys_ctrl_i.csr_rd;
                ctrl_o.csr_wr              = sys_ctrl_i.csr_wr;
                ctrl_o.regd_tgt            = sys_ctrl_i.regd_tgt;
                ctrl_o.regs1_rd            = sys_ctrl_i.regs1_rd;
                ctrl_o.sel_csr_wr_data_imm = sys_ctrl_i.sel_csr_wr_data_imm;
                if (sys_ctrl_i.regd_tgt) begin
                    ctrl_o.zone = ZONE_REGFILE; // csr result to rd
                end
                if (sys_ctrl_i.imm_zimm) begin
                    imm_type_o = IMM_I_ZIMM;
                end
            end
            default: begin
                ctrl_o.ins_err = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/rv32i_decode_stage.sv ====
// Registered RV32I decode stage, one cycle latency, no back-pressure.
// Data outputs hold their last value while ins_valid_i is low.

`timescale 1ns/1ps
`default_nettype none

module rv32i_decode_stage import rv32i_decode_pkg::*; #(
    parameter int unsigned XLEN = 32
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             ins_valid_i,
    input  ins_word_t        ins_i,
    output logic             valid_o,
    output decode_ctrl_t     ctrl_o,
    output logic [XLEN-1:0]  imm_o,
    output reg_addr_t        regd_addr_o,
    output reg_addr_t        regs1_addr_o,
    output reg_addr_t        regs2_addr_o,
    output funct3_t          funct3_o,
    output csr_addr_t        csr_addr_o
);

    sys_ctrl_t        sys_ctrl;
    logic             fence_ok;
    decode_ctrl_t     ctrl_d;
    imm_type_e        imm_type;
    logic [XLEN-1:0]  imm_d;

    // ------------------------------------------------------------------------
    // decode
    // ------------------------------------------------------------------------
    rv32i_system_decoder u_system_decoder (
        .ins_i      (ins_i),
        .sys_ctrl_o (sys_ctrl),
        .fence_ok_o (fence_ok)
    );

    rv32i_major_decoder u_major_decoder (
        .ins_i      (ins_i),
        .sys_ctrl_i (sys_ctrl),
        .fence_ok_i (fence_ok),
        .ctrl_o     (ctrl_d),
        .imm_type_o (imm_type)
    );

    rv32i_imm_gen #(
        .XLEN (XLEN)
    ) u_imm_gen (
        .ins_i      (ins_i),
        .imm_type_i (imm_type),
        .imm_o      (imm_d)
    );

    // ------------------------------------------------------------------------
    // output register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
            ctrl_o  <= '0; // zone none, aluop add
        end else begin
            valid_o <= ins_valid_i;
            if (ins_valid_i) begin
                ctrl_o <= ctrl_d;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (ins_valid_i) begin
            imm_o        <= imm_d;
            regd_addr_o  <= ins_i[11:7];
            regs1_addr_o <= ins_i[19:15];
            regs2_addr_o <= ins_i[24:20];
            funct3_o     <= ins_i[14:12];
            csr_addr_o   <= ins_i[31:20];
        end
    end

endmodule

`default_nettype wire

// ==== verif/rv32i_decode_assertions.sv ====
// Protocol and flag checks for the decode stage, attached by bind.

`timescale 1ns/1ps
`default_nettype none

module rv32i_decode_assertions import rv32i_decode_pkg::*; (
    input logic         clk_i,
    input logic         rst_n_i,
    input logic         ins_valid_i,
    input ins_word_t    ins_i,
    input logic         valid_i,
    input decode_ctrl_t ctrl_i
);

    a_valid_in_reset: assert property (@(posedge clk_i) !rst_n_i |=> !valid_i)
        else $error("valid_o high after a reset cycle");

    a_valid_latency: assert property (@(posedge clk_i)
        rst_n_i |=> (valid_i == $past(ins_valid_i)))
        else $error("valid_o does not follow ins_valid_i by one cycle");

    a_sys_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !ctrl_i.ins_err |-> $onehot0({ctrl_i.fencei, ctrl_i.ecall, ctrl_i.wfi}))
        else $error("fencei, ecall and wfi raised together");

    // flags load only with a valid instruction
    a_csr_wr_system: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ins_valid_i |=> (!ctrl_i.csr_wr || $past(ins_i[6:0]) == OPC_SYSTEM))
        else $error("csr_wr set for a non-system opcode");

endmodule

bind rv32i_decode_stage rv32i_decode_assertions u_assertions (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .ins_valid_i (ins_valid_i),
    .ins_i       (ins_i),
    .valid_i     (valid_o),
    .ctrl_i      (ctrl_o)
);

`default_nettype wire

// ==== verif/tb_rv32i_decode_stage.sv ====
// Directed tests for the decode stage. One cycle latency is assumed fixed,
// so each instruction is checked on the falling edge after its sampling edge.

`timescale 1ns/1ps
`default_nettype none

module tb_rv32i_decode_stage;
    import rv32i_decode_pkg::*;

    localparam int SENDS = 48 + 48 + 29 + 35;
    localparam int LIMIT = 2 * (16 + 2 * SENDS + 13);

    logic         clk_i;
    logic         rst_n_i;
    logic         ins_valid_i;
    ins_word_t    ins_i;
    logic         valid_o;
    decode_ctrl_t ctrl_o;
    logic [31:0]  imm_o;
    reg_addr_t    regd_addr_o;
    reg_addr_t    regs1_addr_o;
    reg_addr_t    regs2_addr_o;
    funct3_t      funct3_o;
    csr_addr_t    csr_addr_o;

    logic [31:0] lfsr = 32'he145_ea44;
    int errs = 0;
    int checks = 0;
    int test_errs = 0;
    int cycles = 0;

    rv32i_decode_stage #(.XLEN(32)) dut_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles > LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("Verification failed");
            $finish;
        end
    end

    // galois lfsr, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return r;
    endfunction

    function automatic alu_op_e exp_aluop(input int f, input logic alt);
        case (f)
            0:       return alt ? ALU_SUB : ALU_ADD;
            1:       return ALU_SLL;
            2:       return ALU_SLT;
            3:       return ALU_SLTU;
            4:       return ALU_XOR;
            5:       return alt ? ALU_SRA : ALU_SRL;
            6:       return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errs++;
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic send(input ins_word_t ins);
        @(posedge clk_i);
        ins_i       <= ins;
        ins_valid_i <= 1'b1;
        @(posedge clk_i);
        ins_valid_i <= 1'b0;
        @(negedge clk_i);
        check(valid_o, 1'b1, "valid_o");
    endtask

    task automatic end_test(input string name);
        $display("test %s done, %0d errors", name, errs - test_errs);
        test_errs = errs;
    endtask

    task automatic reset_state();
        check(valid_o, 1'b0, "valid_o in reset");
        check(ctrl_o, '0, "ctrl_o in reset");
        end_test("reset");
    endtask

    task automatic alu_decode();
        logic [31:0] w;
        logic [6:0]  f7;
        logic        alt;
        logic        err;
        for (int o = 0; o < 2; o++) begin
            for (int f = 0; f < 8; f++) begin
                for (int k = 0; k < 3; k++) begin
                    f7 = (k == 0) ? 7'h00 : (k == 1) ? 7'h20 : 7'h01;
                    w = rand_bits(32);
                    if (o == 0) begin
                        err = !(f7 == 0 || (f7 == 7'h20 && (f == 0 || f == 5)));
                        alt = (f7 == 7'h20);
                    end else begin
                        err = (f == 1) ? (f7 != 0) : (f == 5) ? !(f7 == 0 || f7 == 7'h20) : 0;
                        alt = (f == 5) && (f7 == 7'h20);
                    end
                    send({f7, w[24:15], 3'(f), w[11:7], (o == 0) ? OPC_OP : OPC_OPIMM});
                    check(ctrl_o.aluop, exp_aluop(f, alt), "aluop");
                    check(ctrl_o.ins_err, err, "ins_err");
                    check(ctrl_o.sels2_imm, o, "sels2_imm");
                    check(ctrl_o.regs2_rd, o == 0, "regs2_rd");
                    check(ctrl_o.regs1_rd, 1'b1, "regs1_rd");
                    check(ctrl_o.regd_tgt, 1'b1, "regd_tgt");
                    check(ctrl_o.selcmps2_imm, o == 1 && (f == 2 || f == 3), "selcmps2_imm");
                end
            end
        end
        end_test("alu");
    endtask

    task automatic imm_formats();
        logic [31:0] w;
        for (int i = 0; i < 8; i++) begin
            w = rand_bits(32);
            send({w[31:15], 3'b000, w[11:7], OPC_OPIMM});
            check(imm_o, {{20{w[31]}}, w[31:20]}, "imm I");
            check(regd_addr_o, w[11:7], "rd");
            check(regs1_addr_o, w[19:15], "rs1");
            check(regs2_addr_o, w[24:20], "rs2");
            check(csr_addr_o, w[31:20], "csr addr");
            send({w[31:15], 3'b010, w[11:7], OPC_STORE});
            check(imm_o, {{20{w[31]}}, w[31:25], w[11:7]}, "imm S");
            check(funct3_o, 3'b010, "funct3");
            send({w[31:15], 3'b000, w[11:7], OPC_BRANCH});
            check(imm_o, {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0}, "imm SB");
            send({w[31:7], OPC_LUI});
            check(imm_o, {w[31:12], 12'b0}, "imm U");
            send({w[31:7], OPC_JAL});
            check(imm_o, {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0}, "imm UJ");
            send({w[31:15], 3'b110, w[11:7], OPC_SYSTEM});
            check(imm_o, {27'b0, w[19:15]}, "imm csr zimm");
        end
        end_test("immediates");
    endtask

    task automatic mem_flow_decode();
        logic [31:0] w;
        for (int f = 0; f < 8; f++) begin
            w = rand_bits(32);
            send({w[31:15], 3'(f), w[11:7], OPC_LOAD});
            check(ctrl_o.ins_err, f == 3 || f >= 6, "load ins_err");
            check(ctrl_o.zone, ZONE_LOADQ, "load zone");
            send({w[31:15], 3'(f), w[11:7], OPC_STORE});
            check(ctrl_o.ins_err, f >= 3, "store ins_err");
            check(ctrl_o.zone, ZONE_STOREQ, "store zone");
            send({w[31:15], 3'(f), w[11:7], OPC_BRANCH});
            check(ctrl_o.ins_err, f == 2 || f == 3, "branch ins_err");
            check({ctrl_o.jump, ctrl_o.conditional, ctrl_o.link}, 3'b110, "branch flags");
        end
        w = rand_bits(32);
        send({w[31:7], OPC_JAL});
        check({ctrl_o.jump, ctrl_o.link, ctrl_o.ins_err}, 3'b110, "jal flags");
        check(ctrl_o.zone, ZONE_REGFILE, "jal zone");
        send({w[31:15], 3'b000, w[11:7], OPC_JALR});
        check({ctrl_o.jump, ctrl_o.link, ctrl_o.ins_err}, 3'b110, "jalr flags");
        send({w[31:15], 3'b001, w[11:7], OPC_JALR});
        check(ctrl_o.ins_err, 1'b1, "jalr bad funct3");
        send({w[31:7], OPC_LUI});
        check(ctrl_o.aluop, ALU_MOV, "lui aluop");
        check(ctrl_o.ins_err, 1'b0, "lui ins_err");
        send({w[31:7], OPC_AUIPC});
        check({ctrl_o.jump, ctrl_o.sels1_pc, ctrl_o.ins_err}, 3'b010, "auipc flags");
        end_test("memory and control flow");
    endtask

    task automatic system_decode();
        logic [31:0] w;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        int          f3s[6] = '{1, 2, 3, 5, 6, 7};
        ins_word_t   bad[7] = '{32'h3020_0073, 32'h1020_0073, 32'h0010_0073,
                                32'h0000_4073, 32'h0000_007f, 32'h0ff0_008f,
                                32'h0000_0000};
        foreach (f3s[i]) begin
            for (int k = 0; k < 4; k++) begin
                w = rand_bits(32);
                rd = k[0] ? (w[11:7] | 5'd1) : 5'd0;
                rs1 = k[1] ? (w[19:15] | 5'd1) : 5'd0;
                send({w[31:20], rs1, 3'(f3s[i]), rd, OPC_SYSTEM});
                check(ctrl_o.csr_rd, rd != 0, "csr_rd");
                check(ctrl_o.csr_wr, rs1 != 0 || f3s[i] == 1 || f3s[i] == 5, "csr_wr");
                check(ctrl_o.regs1_rd, f3s[i] < 4, "csr regs1_rd");
                check(ctrl_o.sel_csr_wr_data_imm, f3s[i] > 4, "csr imm select");
                check(ctrl_o.ins_err, 1'b0, "csr ins_err");
                check(ctrl_o.zone, ZONE_REGFILE, "csr zone");
            end
        end
        send(32'h0000_0073);
        check({ctrl_o.ecall, ctrl_o.wfi, ctrl_o.ins_err}, 3'b100, "ecall");
        send(32'h1050_0073);
        check({ctrl_o.ecall, ctrl_o.wfi, ctrl_o.ins_err}, 3'b010, "wfi");
        send(32'h0ff0_000f); // fence iorw, iorw
        check({ctrl_o.fencei, ctrl_o.ins_err}, 2'b10, "fence");
        send(32'h0000_100f);
        check({ctrl_o.fencei, ctrl_o.ins_err}, 2'b10, "fence.i");
        // mret, sret, ebreak, funct3 100, unknown opcodes, fence with rd
        foreach (bad[i]) begin
            send(bad[i]);
            check(ctrl_o.ins_err, 1'b1, "illegal ins_err");
        end
        end_test("system");
    endtask

    task automatic stream_order();
        logic [31:0] w;
        logic        v;
        logic        prev_v = 1'b0;
        reg_addr_t   prev_rd = '0;
        reg_addr_t   last_rd = regd_addr_o;
        int          n_in = 0;
        int          n_out = 0;
        for (int i = 0; i < 13; i++) begin
            w = rand_bits(32);
            v = (i < 12) && (i % 4 != 3);
            @(posedge clk_i);
            ins_i       <= {w[31:7], OPC_LUI};
            ins_valid_i <= v;
            @(negedge clk_i);
            check(valid_o, prev_v, "stream valid_o");
            if (prev_v) begin
                last_rd = prev_rd;
            end
            if (valid_o === 1'b1) begin
                n_out++;
            end
            check(regd_addr_o, last_rd, "stream rd");
            n_in += v;
            prev_v = v;
            prev_rd = w[11:7];
        end
        check(n_out, n_in, "stream output count");
        end_test("streaming");
    endtask

    initial begin
        rst_n_i     = 1'b0;
        ins_valid_i = 1'b0;
        ins_i       = '0;
        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        reset_state();
        @(posedge clk_i);
        rst_n_i <= 1'b1;
        alu_decode();
        imm_formats();
        mem_flow_decode();
        system_decode();
        stream_order();
        $display("checks %0d, errors %0d", checks, errs);
        if (errs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
hw/rv32i_decode_pkg.sv
hw/rv32i_imm_gen.sv
hw/rv32i_system_decoder.sv
hw/rv32i_major_decoder.sv
hw/rv32i_decode_stage.sv
verif/rv32i_decode_assertions.sv
verif/tb_rv32i_decode_stage.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing --assert -Wno-fatal
TOP       ?= tb_rv32i_decode_stage
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
		exit 1; \
	fi
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
